/* design/host_ctrl_pkg.sv */
// host control package: cpu bus op bits, control register bits and word widths
package host_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // word widths
    //////////////////////////////////////////////////////////////////////

    // op, par and ctrl words
    localparam int word_w = 16;

    // cpu top-of-stack value
    localparam int tos_w = 32;

    // width of each id field in the status word
    localparam int field_w = 4;

    //////////////////////////////////////////////////////////////////////
    // op word bit positions
    //////////////////////////////////////////////////////////////////////

    // write tos[15:0] into the control register
    localparam int op_set_ctrl = 4;

    // read the status word onto par
    localparam int op_get_status = 5;

    // read the noted service request onto ser
    localparam int op_get_srq = 6;

    //////////////////////////////////////////////////////////////////////
    // control register bit positions
    //////////////////////////////////////////////////////////////////////

    // adc oscillator clock enable
    localparam int ctrl_osc_en = 8;
    // eeprom write protect
    localparam int ctrl_eeprom_wp = 9;
    // interrupt line to the host
    localparam int ctrl_interrupt = 10;
    // spare pin driven from the register
    localparam int ctrl_unused_out = 11;

endpackage

/* design/ovfl_pulse_sync.sv */
// overflow strobe crossing: adc_clk strobe to a single cpu_clk pulse via toggle sync
`timescale 1ns/1ns

module ovfl_pulse_sync (
    input  logic adc_clk,
    input  logic adc_ovfl,
    input  logic cpu_clk,
    input  logic rx_ovfl_rst,
    output logic rx_ovfl
);

    //////////////////////////////////////////////////////////////////////
    // adc_clk side
    //////////////////////////////////////////////////////////////////////

    // toggle powers up low so the cpu side sees no edge at start
    logic ovfl_tgl = 1'b0;

    // one flip per overflow strobe
    always_ff @(posedge adc_clk)
    begin
        ovfl_tgl <= ovfl_tgl ^ adc_ovfl;
    end

    //////////////////////////////////////////////////////////////////////
    // cpu_clk side
    //////////////////////////////////////////////////////////////////////

    // three-stage synchronizer, first two resolve metastability
    logic [2:0] tgl_sync;

    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
        begin
            // last two stages held equal so a toggle left high by an earlier
            // overflow is not seen as a new one when reset ends
            tgl_sync <= {tgl_sync[0], tgl_sync[0], ovfl_tgl};
        end
        else
        begin
            tgl_sync <= {tgl_sync[1:0], ovfl_tgl};
        end
    end

    // any change between the last two stages is one overflow
    assign rx_ovfl = tgl_sync[2] ^ tgl_sync[1];

endmodule

/* design/rx_status_capture.sv */
// receiver status capture: sticky overflow flag and read-clear service request
`timescale 1ns/1ns

module rx_status_capture (
    input  logic                             cpu_clk,
    input  logic                             rx_ovfl_rst,
    input  logic                             rx_ovfl,
    input  logic                             host_srq,
    input  logic                             rd_reg,
    input  logic [host_ctrl_pkg::word_w-1:0] op,
    output logic                             rx_overflow,
    output logic                             srq_out
);

    //////////////////////////////////////////////////////////////////////
    // overflow flag
    //////////////////////////////////////////////////////////////////////

    // sticky until the next reset
    // reset loads the live pulse so an overflow during reset is not lost
    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
        begin
            rx_overflow <= rx_ovfl;
        end
        else
        begin
            rx_overflow <= rx_overflow | rx_ovfl;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // service request
    //////////////////////////////////////////////////////////////////////

    // cpu polls for host service with a get-srq read
    logic srq_rd;
    logic srq_noted;

    assign srq_rd = rd_reg & op[host_ctrl_pkg::op_get_srq];

    // noted request accumulates between reads
    // a read hands it to srq_out and restarts from the live request
    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
        begin
            srq_noted <= 1'b0;
            srq_out   <= 1'b0;
        end
        else if (srq_rd)
        begin
            srq_noted <= host_srq;
            srq_out   <= srq_noted;
        end
        else
        begin
            // srq_out keeps the last read result
            srq_noted <= srq_noted | host_srq;
        end
    end

endmodule

/* design/ctrl_reg_file.sv */
// control register: cpu-written 16-bit word and the board pins decoded from it
`timescale 1ns/1ns

module ctrl_reg_file (
    input  logic                             cpu_clk,
    input  logic                             rx_ovfl_rst,
    input  logic                             wr_reg2,
    input  logic [host_ctrl_pkg::word_w-1:0] op,
    input  logic [host_ctrl_pkg::tos_w-1:0]  tos,
    output logic [host_ctrl_pkg::word_w-1:0] ctrl_word,
    output logic                             adc_clken,
    output logic                             eewp,
    output logic                             interrupt,
    output logic                             unused_out
);

    //////////////////////////////////////////////////////////////////////
    // register write
    //////////////////////////////////////////////////////////////////////

    logic ctrl_wr;

    // write strobe qualified by the set-ctrl op bit
    assign ctrl_wr = wr_reg2 & op[host_ctrl_pkg::op_set_ctrl];

    // only the low half of tos carries the control word
    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
        begin
            ctrl_word <= '0;
        end
        else if (ctrl_wr)
        begin
            ctrl_word <= tos[host_ctrl_pkg::word_w-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // pin decode
    //////////////////////////////////////////////////////////////////////

    // adc oscillator enable
    assign adc_clken  = ctrl_word[host_ctrl_pkg::ctrl_osc_en];
    // eeprom write protect, high protects
    assign eewp       = ctrl_word[host_ctrl_pkg::ctrl_eeprom_wp];
    // interrupt to the host
    assign interrupt  = ctrl_word[host_ctrl_pkg::ctrl_interrupt];
    // spare output pin
    assign unused_out = ctrl_word[host_ctrl_pkg::ctrl_unused_out];

endmodule

/* design/par_read_mux.sv */
// cpu parallel read port: registered status word or host data onto par
`timescale 1ns/1ns

module par_read_mux #(
    parameter logic [host_ctrl_pkg::field_w-1:0] FPGA_VER = 4'd1,
    parameter logic [host_ctrl_pkg::field_w-1:0] CLOCK_ID = 4'd0,
    parameter logic [host_ctrl_pkg::field_w-1:0] FPGA_ID  = 4'd2
) (
    input  logic                             cpu_clk,
    input  logic                             rx_ovfl_rst,
    input  logic                             rd_reg,
    input  logic [host_ctrl_pkg::word_w-1:0] op,
    input  logic                             rx_overflow,
    input  logic [host_ctrl_pkg::word_w-1:0] host_dout,
    output logic [host_ctrl_pkg::word_w-1:0] par
);

    //////////////////////////////////////////////////////////////////////
    // status word
    //////////////////////////////////////////////////////////////////////

    logic [host_ctrl_pkg::word_w-1:0] status_word;

    // bit 15 overflow, 14..12 reserved zero, then version, clock and board id
    assign status_word = {rx_overflow, 3'b000, FPGA_VER, CLOCK_ID, FPGA_ID};

    //////////////////////////////////////////////////////////////////////
    // read select
    //////////////////////////////////////////////////////////////////////

    logic [host_ctrl_pkg::word_w-1:0] rd_word;

    // status wins over host data when both could apply
    always_comb
    begin
        if (op[host_ctrl_pkg::op_get_status])
        begin
            rd_word = status_word;
        end
        else
        begin
            rd_word = host_dout;
        end
    end

    // captured on the read strobe, cpu samples it the next cycle
    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
        begin
            par <= '0;
        end
        else if (rd_reg)
        begin
            par <= rd_word;
        end
    end

endmodule

/* design/host_ctrl_status.sv */
// host control and status top: overflow sync, status capture, control register and read port
`timescale 1ns/1ns

module host_ctrl_status #(
    parameter logic [host_ctrl_pkg::field_w-1:0] FPGA_VER = 4'd1,
    parameter logic [host_ctrl_pkg::field_w-1:0] CLOCK_ID = 4'd0,
    parameter logic [host_ctrl_pkg::field_w-1:0] FPGA_ID  = 4'd2
) (
    input  logic                             cpu_clk,
    input  logic                             rx_ovfl_rst,
    input  logic                             adc_clk,
    input  logic                             adc_ovfl,
    input  logic                             host_srq,
    input  logic [host_ctrl_pkg::word_w-1:0] host_dout,
    input  logic [host_ctrl_pkg::word_w-1:0] op,
    input  logic [host_ctrl_pkg::tos_w-1:0]  tos,
    input  logic                             rd_reg,
    input  logic                             wr_reg2,
    output logic [host_ctrl_pkg::word_w-1:0] par,
    output logic                             ser,
    output logic                             adc_clken,
    output logic                             eewp,
    output logic                             interrupt,
    output logic                             unused_out
);

    //////////////////////////////////////////////////////////////////////
    // stage wires
    //////////////////////////////////////////////////////////////////////

    // single cpu_clk pulse per adc overflow
    logic                             rx_ovfl;
    // sticky overflow flag for the status word
    logic                             rx_overflow;

    //////////////////////////////////////////////////////////////////////
    // stages
    //////////////////////////////////////////////////////////////////////

    // adc_clk to cpu_clk crossing
    ovfl_pulse_sync ovfl_pulse_sync_i (
        .adc_clk     (adc_clk),
        .adc_ovfl    (adc_ovfl),
        .cpu_clk     (cpu_clk),
        .rx_ovfl_rst (rx_ovfl_rst),
        .rx_ovfl     (rx_ovfl)
    );

    // overflow flag and service request, srq result goes out on ser
    rx_status_capture rx_status_capture_i (
        .cpu_clk     (cpu_clk),
        .rx_ovfl_rst (rx_ovfl_rst),
        .rx_ovfl     (rx_ovfl),
        .host_srq    (host_srq),
        .rd_reg      (rd_reg),
        .op          (op),
        .rx_overflow (rx_overflow),
        .srq_out     (ser)
    );

    // only the decoded pins leave the block
    ctrl_reg_file ctrl_reg_file_i (
        .cpu_clk     (cpu_clk),
        .rx_ovfl_rst (rx_ovfl_rst),
        .wr_reg2     (wr_reg2),
        .op          (op),
        .tos         (tos),
        .ctrl_word   (),
        .adc_clken   (adc_clken),
        .eewp        (eewp),
        .interrupt   (interrupt),
        .unused_out  (unused_out)
    );

    // id fields passed down from here
    par_read_mux #(
        .FPGA_VER (FPGA_VER),
        .CLOCK_ID (CLOCK_ID),
        .FPGA_ID  (FPGA_ID)
    ) par_read_mux_i (
        .cpu_clk     (cpu_clk),
        .rx_ovfl_rst (rx_ovfl_rst),
        .rd_reg      (rd_reg),
        .op          (op),
        .rx_overflow (rx_overflow),
        .host_dout   (host_dout),
        .par         (par)
    );

endmodule

/* test/host_ctrl_status_props.sv */
// bus, control and overflow rules of the host control and status block, bound to the top
`timescale 1ns/1ns

module host_ctrl_status_props #(
    parameter logic [host_ctrl_pkg::field_w-1:0] FPGA_VER = 4'd1,
    parameter logic [host_ctrl_pkg::field_w-1:0] CLOCK_ID = 4'd0,
    parameter logic [host_ctrl_pkg::field_w-1:0] FPGA_ID  = 4'd2
) (
    input logic                             cpu_clk,
    input logic                             rx_ovfl_rst,
    input logic [host_ctrl_pkg::word_w-1:0] op,
    input logic [host_ctrl_pkg::tos_w-1:0]  tos,
    input logic                             rd_reg,
    input logic                             wr_reg2,
    input logic [host_ctrl_pkg::word_w-1:0] host_dout,
    input logic                             rx_ovfl,
    input logic                             rx_overflow,
    input logic [host_ctrl_pkg::word_w-1:0] par,
    input logic                             ser,
    input logic                             adc_clken,
    input logic                             eewp,
    input logic                             interrupt,
    input logic                             unused_out
);

    // failed rules so far, the testbench adds these to its totals
    int fail_cnt = 0;

    logic       ctrl_wr;
    logic       srq_rd;
    logic [3:0] pins;

    assign ctrl_wr = wr_reg2 & op[host_ctrl_pkg::op_set_ctrl];
    assign srq_rd  = rd_reg & op[host_ctrl_pkg::op_get_srq];
    assign pins    = {unused_out, interrupt, eewp, adc_clken};

    task automatic record_failure(input string what);
        fail_cnt++;
        $error("%s", what);
    endtask

    //////////////////////////////////////////////////////////////////////
    // control register
    //////////////////////////////////////////////////////////////////////

    // reset clears the read port, ser and every pin
    reset_clears: assert property (@(posedge cpu_clk)
        rx_ovfl_rst |=> par == '0 && !ser && pins == 4'b0000)
        else record_failure("outputs not cleared by reset");

    // pins follow their bits of tos one cycle after a set-ctrl write
    ctrl_write: assert property (@(posedge cpu_clk)
        ctrl_wr && !rx_ovfl_rst |=> pins == $past({tos[host_ctrl_pkg::ctrl_unused_out],
            tos[host_ctrl_pkg::ctrl_interrupt], tos[host_ctrl_pkg::ctrl_eeprom_wp],
            tos[host_ctrl_pkg::ctrl_osc_en]}))
        else record_failure("control pins do not match the written tos bits");

    // no set-ctrl write, no pin change
    ctrl_hold: assert property (@(posedge cpu_clk)
        !ctrl_wr && !rx_ovfl_rst |=> $stable(pins))
        else record_failure("control pins changed without a set-ctrl write");

    //////////////////////////////////////////////////////////////////////
    // read port and status
    //////////////////////////////////////////////////////////////////////

    // status word when get-status is set, host data otherwise
    read_word: assert property (@(posedge cpu_clk)
        rd_reg && !rx_ovfl_rst |=> par == ($past(op[host_ctrl_pkg::op_get_status]) ?
            {$past(rx_overflow), 3'b000, FPGA_VER, CLOCK_ID, FPGA_ID} : $past(host_dout)))
        else record_failure("par does not hold the word selected by the read");

    // overflow sets the flag and it stays until reset
    ovfl_sticky: assert property (@(posedge cpu_clk)
        (rx_ovfl || rx_overflow) && !rx_ovfl_rst |=> rx_overflow)
        else record_failure("rx_overflow not set or not held");

    // ser moves only on a get-srq read
    ser_hold: assert property (@(posedge cpu_clk)
        !srq_rd && !rx_ovfl_rst |=> $stable(ser))
        else record_failure("ser changed without a get-srq read");

endmodule

/* test/host_ctrl_status_tb.sv */
// testbench for the host control and status block: bus stimulus and per-test report
`timescale 1ns/1ns

module host_ctrl_status_tb #(
    parameter logic [31:0] SEED = 32'h93146327
);

    // id fields given to the DUT, expected back in the status word
    localparam logic [3:0] fpga_ver = 4'h3;
    localparam logic [3:0] clock_id = 4'h5;
    localparam logic [3:0] fpga_id  = 4'h9;
    // crossing latency window in cpu_clk cycles, and the wait limit
    localparam int ovfl_min   = 3;
    localparam int ovfl_max   = 5;
    localparam int wait_limit = 12;
    // one-hot op words
    localparam logic [15:0] ctrl_op   = 16'h0001 << host_ctrl_pkg::op_set_ctrl;
    localparam logic [15:0] status_op = 16'h0001 << host_ctrl_pkg::op_get_status;
    localparam logic [15:0] srq_op    = 16'h0001 << host_ctrl_pkg::op_get_srq;

    logic        cpu_clk;
    logic        rx_ovfl_rst;
    logic        adc_clk;
    logic        adc_ovfl;
    logic        host_srq;
    logic [15:0] host_dout;
    logic [15:0] op;
    logic [31:0] tos;
    logic        rd_reg;
    logic        wr_reg2;
    logic [15:0] par;
    logic        ser;
    logic        adc_clken;
    logic        eewp;
    logic        interrupt;
    logic        unused_out;

    int seed;
    int errors;
    int tests_run;
    int tests_failed;
    int test_start;

    host_ctrl_status #(
        .FPGA_VER (fpga_ver),
        .CLOCK_ID (clock_id),
        .FPGA_ID  (fpga_id)
    ) host_ctrl_status_i (.*);

    bind host_ctrl_status host_ctrl_status_props #(
        .FPGA_VER (FPGA_VER),
        .CLOCK_ID (CLOCK_ID),
        .FPGA_ID  (FPGA_ID)
    ) props_i (.*);

    initial
    begin
        cpu_clk = 1'b0;
        forever #5 cpu_clk = ~cpu_clk;
    end

    // 13 ns adc clock, rising edges at 7 + 13k
    initial
    begin
        adc_clk = 1'b0;
        forever
        begin
            #7 adc_clk = 1'b1;
            #6 adc_clk = 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks and report
    //////////////////////////////////////////////////////////////////////

    function automatic int total_errors();
        return errors + host_ctrl_status_i.props_i.fail_cnt;
    endfunction

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        assert (act === exp)
        else
        begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        assert (act === exp)
        else
        begin
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        int found;
        found = total_errors() - test_start;
        tests_run++;
        if (found != 0)
        begin
            tests_failed++;
            $display("test %s failed with %0d error(s)", name, found);
        end
        else
        begin
            $display("test %s passed", name);
        end
        test_start = total_errors();
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic apply_reset();
        @(posedge cpu_clk);
        rx_ovfl_rst <= 1'b1;
        repeat (5) @(posedge cpu_clk);
        rx_ovfl_rst <= 1'b0;
        @(negedge cpu_clk);
    endtask

    // one-cycle write strobe, result sampled on the following falling edge
    task automatic bus_write(input logic [15:0] op_bits, input logic [31:0] value);
        @(posedge cpu_clk);
        op      <= op_bits;
        tos     <= value;
        wr_reg2 <= 1'b1;
        @(posedge cpu_clk);
        op      <= '0;
        wr_reg2 <= 1'b0;
        @(negedge cpu_clk);
    endtask

    task automatic bus_read(input logic [15:0] op_bits, input logic [15:0] data);
        @(posedge cpu_clk);
        op        <= op_bits;
        host_dout <= data;
        rd_reg    <= 1'b1;
        @(posedge cpu_clk);
        op     <= '0;
        rd_reg <= 1'b0;
        @(negedge cpu_clk);
    endtask

    task automatic srq_pulse();
        @(posedge cpu_clk);
        host_srq <= 1'b1;
        @(posedge cpu_clk);
        host_srq <= 1'b0;
    endtask

    // one adc_clk overflow strobe, then count cpu_clk cycles until the flag rises
    task automatic overflow_pulse(output int cycles, output bit seen);
        longint now;
        int tries;
        tries = 0;
        @(posedge adc_clk);
        now = $time;
        // keep the strobe off cpu_clk edges so the cycle count is exact
        while ((now % 64'd5) == 64'd0 && tries < wait_limit)
        begin
            @(posedge adc_clk);
            now = $time;
            tries++;
        end
        adc_ovfl <= 1'b1;
        fork
            begin
                @(posedge adc_clk);
                adc_ovfl <= 1'b0;
            end
        join_none
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < wait_limit)
        begin
            @(negedge cpu_clk);
            cycles++;
            seen = host_ctrl_status_i.rx_overflow;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        logic [31:0] value;
        logic [15:0] data;
        logic [3:0]  pins;
        int          cycles;
        bit          seen;
        seed = SEED;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        test_start = 0;
        rx_ovfl_rst = 1'b1;
        adc_ovfl = 1'b0;
        host_srq = 1'b0;
        host_dout = '0;
        op = '0;
        tos = '0;
        rd_reg = 1'b0;
        wr_reg2 = 1'b0;

        apply_reset();
        check_word("par", 16'h0000, par);
        check_bit("ser", 1'b0, ser);
        check_word("ctrl pins", 16'h0000, {12'h000, unused_out, interrupt, eewp, adc_clken});
        end_test("reset_state");

        repeat (4)
        begin
            value = $random(seed);
            bus_write(ctrl_op, value);
            check_bit("adc_clken", value[host_ctrl_pkg::ctrl_osc_en], adc_clken);
            check_bit("eewp", value[host_ctrl_pkg::ctrl_eeprom_wp], eewp);
            check_bit("interrupt", value[host_ctrl_pkg::ctrl_interrupt], interrupt);
            check_bit("unused_out", value[host_ctrl_pkg::ctrl_unused_out], unused_out);
        end
        // a write under another op must leave the pins at the last written tos bits
        pins = {value[host_ctrl_pkg::ctrl_unused_out], value[host_ctrl_pkg::ctrl_interrupt],
            value[host_ctrl_pkg::ctrl_eeprom_wp], value[host_ctrl_pkg::ctrl_osc_en]};
        bus_write(status_op, ~value);
        check_word("ctrl pins", {12'h000, pins}, {12'h000, unused_out, interrupt, eewp, adc_clken});
        end_test("ctrl_write");

        bus_read(status_op, 16'($random(seed)));
        check_word("par", {1'b0, 3'b000, fpga_ver, clock_id, fpga_id}, par);
        end_test("status_read");

        overflow_pulse(cycles, seen);
        if (!seen)
        begin
            $display("timeout: rx_overflow did not rise within %0d cpu_clk cycles", wait_limit);
            errors++;
        end
        else if (cycles < ovfl_min || cycles > ovfl_max)
        begin
            $display("overflow latency of %0d cycles is outside %0d to %0d", cycles, ovfl_min,
                ovfl_max);
            errors++;
        end
        repeat (2)
        begin
            bus_read(status_op, 16'($random(seed)));
            check_word("par", {1'b1, 3'b000, fpga_ver, clock_id, fpga_id}, par);
        end
        apply_reset();
        // flag must stay clear over several reads once reset has ended
        repeat (2)
        begin
            bus_read(status_op, 16'($random(seed)));
            check_word("par", {1'b0, 3'b000, fpga_ver, clock_id, fpga_id}, par);
        end
        end_test("overflow_sticky");

        srq_pulse();
        bus_read(srq_op, 16'($random(seed)));
        check_bit("ser", 1'b1, ser);
        bus_read(srq_op, 16'($random(seed)));
        check_bit("ser", 1'b0, ser);
        end_test("srq_capture");

        repeat (4)
        begin
            data = 16'($random(seed));
            bus_read(16'h0000, data);
            check_word("par", data, par);
        end
        end_test("host_passthru");

        $display("tests %0d, failed %0d, value errors %0d, assertion errors %0d", tests_run,
            tests_failed, errors, host_ctrl_status_i.props_i.fail_cnt);
        if (total_errors() == 0 && tests_failed == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* host_ctrl_status.f */
design/host_ctrl_pkg.sv
design/ovfl_pulse_sync.sv
design/rx_status_capture.sv
design/ctrl_reg_file.sv
design/par_read_mux.sv
design/host_ctrl_status.sv
test/host_ctrl_status_props.sv
test/host_ctrl_status_tb.sv

/* Makefile */
# Verilator lint, simulation and clean for the host control and status block
# any variable below can be overridden, e.g. make sim SEED=32'h12345678 LOG=run.log

VERILATOR ?= verilator
TOP       ?= host_ctrl_status_tb
FILELIST  ?= host_ctrl_status.f
SEED      ?= 32'h93146327
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
ERR_LIMIT ?= 100
VFLAGS    ?= --timing --assert --top-module $(TOP) -f $(FILELIST)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

# the log decides the result, the run itself may end early on an error limit
sim:
	$(VERILATOR) --binary $(VFLAGS) "-GSEED=$(SEED)" -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || { echo "simulation did not complete, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
